// File: source/mac_cfg.svh
`ifndef MAC_CFG_SVH
`define MAC_CFG_SVH

// ======================================================================
// Timing constants
// ======================================================================

// Clocks per Timer 2 tick
`define VIA_TICK_DIV          32'd20

// Vertical blanks per one-second flag
`define VIA_FRAMES_PER_SEC    32'd60

// ======================================================================
// VIA reset and read values
// ======================================================================

`define VIA_ORA_RESET         8'h7F   // Overlay bit 4 high
`define VIA_ORB_RESET         8'hFF

// Low half of the data bus on VIA reads
`define VIA_LOW_FILL          8'hEF

// Unmapped VIA index
`define VIA_READ_DEFAULT      8'hBE

// ======================================================================
// Address map
// ======================================================================

// RAM base once the overlay is off
`define MAC_RAM_BASE_NORMAL   24'h600000

`endif

// File: source/mac_pkg.sv
package mac_pkg;

  // ======================================================================
  // CPU bus and device selects
  // ======================================================================

  // 68000 bus as seen by the glue logic
  typedef struct packed {
    logic [23:1] addr;   // Word address
    logic        rw;     // 1 read, 0 write
    logic        as_n;   // Address strobe
    logic        uds_n;  // Upper byte strobe, VIA lives here
    logic        lds_n;  // Lower byte strobe
    logic [15:0] wdata;  // Data from CPU
  } mac_bus_t;

  // One-hot chip selects
  typedef struct packed {
    logic rom;
    logic ram;
    logic via;
    logic scc;
    logic iwm;
    logic scsi;
  } mac_sel_t;

  // ======================================================================
  // VIA register map and interrupt bits
  // ======================================================================

  // Register index from address bits 12:9
  typedef enum logic [3:0] {
    REG_ORB  = 4'h0,
    REG_DDRB = 4'h2,
    REG_DDRA = 4'h3,
    REG_T1CL = 4'h4,
    REG_T1CH = 4'h5,
    REG_T1LL = 4'h6,
    REG_T1LH = 4'h7,
    REG_T2CL = 4'h8,
    REG_T2CH = 4'h9,
    REG_SR   = 4'hA,
    REG_ACR  = 4'hB,
    REG_PCR  = 4'hC,
    REG_IFR  = 4'hD,
    REG_IER  = 4'hE,
    REG_ORA  = 4'hF
  } via_reg_e;

  // Bit positions in IFR and IER
  typedef enum logic [2:0] {
    IRQ_ONESEC   = 3'd0,
    IRQ_VBLANK   = 3'd1,
    IRQ_KEYREADY = 3'd2,
    IRQ_KEYBIT   = 3'd3,
    IRQ_KEYCLK   = 3'd4,
    IRQ_T2       = 3'd5,
    IRQ_T1       = 3'd6
  } via_irq_e;

endpackage

// File: source/mac_bus_decode.sv
`timescale 1ns/100ps

`include "mac_cfg.svh"

module mac_bus_decode (
  input  mac_pkg::mac_bus_t i_bus,
  input  logic              i_overlay,    // ROM mirrored at 0 when low
  input  logic [7:0]        i_via_rdata,
  input  logic              i_via_irq,
  input  logic [15:0]       i_mem_rdata,
  output mac_pkg::mac_sel_t o_sel,
  output logic [15:0]       o_rdata,
  output logic [2:0]        o_ipl_n
);

  import mac_pkg::*;

  // Top nibble of the normal RAM base
  localparam logic [3:0] RAM_BANK = 4'(`MAC_RAM_BASE_NORMAL >> 20);

  mac_sel_t   sel;
  logic [3:0] addr_hi;

  assign addr_hi = i_bus.addr[23:20];

  // ======================================================================
  // Chip selects
  // ======================================================================
  always_comb begin
    sel = '0;
    casez (addr_hi)
      4'b00??: begin                        // Low 4 MB
        if (i_overlay) begin
          sel.ram = 1'b1;
        end else begin
          sel.rom = 1'b1;
        end
      end
      4'b0100: sel.rom  = ~i_bus.addr[17];  // ROM image, upper half unused
      4'b0101: sel.scsi = (i_bus.addr[19:12] == 8'h80);
      RAM_BANK: sel.ram = ~i_overlay;       // RAM moved up during boot
      4'b10?1: sel.scc  = 1'b1;             // SCC read and write banks
      4'b1101: sel.iwm  = 1'b1;
      4'b1110: sel.via  = 1'b1;
      default: ;
    endcase
  end

  assign o_sel = sel;

  // ======================================================================
  // Read data to the CPU
  // ======================================================================

  // VIA sits on the upper byte lane
  always_comb begin
    if (sel.via) begin
      o_rdata = {i_via_rdata, `VIA_LOW_FILL};
    end else if (sel.ram || sel.rom) begin
      o_rdata = i_mem_rdata;
    end else begin
      o_rdata = 16'h0000;   // SCC, IWM, SCSI and holes
    end
  end

  // ======================================================================
  // Interrupt priority
  // ======================================================================

  // VIA is level 1, nothing else requests
  assign o_ipl_n = i_via_irq ? 3'b110 : 3'b111;

endmodule

// File: source/via_timer2.sv
`timescale 1ns/100ps

`include "mac_cfg.svh"

module via_timer2 (
  input  logic        clk_cpu,
  input  logic        reset,
  input  logic        i_load,        // T2CH write
  input  logic [15:0] i_load_count,
  input  logic        i_ack,         // T2 flag taken by software
  output logic [15:0] o_count,
  output logic        o_fire
);

  localparam int DIV = `VIA_TICK_DIV;
  localparam int PW  = $clog2(DIV);
  localparam logic [PW-1:0] PRE_LAST = PW'(DIV - 1);

  logic [PW-1:0] prescale;
  logic          tick;
  logic          armed;      // One-shot pending
  logic [15:0]   count;

  assign tick = (prescale == '0);

  // Free-running divider, never restarted
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      prescale <= '0;
    end else if (prescale == PRE_LAST) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // ======================================================================
  // Countdown and one-shot
  // ======================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      count  <= '0;
      armed  <= 1'b0;
      o_fire <= 1'b0;
    end else begin
      o_fire <= 1'b0;
      if (i_load) begin
        count <= i_load_count;
        armed <= 1'b1;             // Load wins over a tick
      end else begin
        if (i_ack) armed <= 1'b0;  // Cancel a stale countdown
        if (tick) begin
          count <= count - 1'b1;   // Keeps rolling past zero
          if (armed && count == 16'h0000) begin
            armed  <= 1'b0;
            o_fire <= 1'b1;
          end
        end
      end
    end
  end

  assign o_count = count;

endmodule

// File: source/via_frame_events.sv
`timescale 1ns/100ps

`include "mac_cfg.svh"

module via_frame_events (
  input  logic clk_cpu,
  input  logic reset,
  input  logic i_vsync,
  output logic o_vblank,   // One cycle per frame
  output logic o_onesec    // One cycle per second
);

  localparam int FRAMES = `VIA_FRAMES_PER_SEC;
  localparam int CW     = $clog2(FRAMES);
  localparam logic [CW-1:0] FRAME_LAST = CW'(FRAMES - 1);

  logic          vsync_q;
  logic          fall;
  logic [CW-1:0] frame_cnt;

  // Start of vertical blank
  assign fall = vsync_q & ~i_vsync;

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_q   <= 1'b0;   // No edge right out of reset
      frame_cnt <= '0;
      o_vblank  <= 1'b0;
      o_onesec  <= 1'b0;
    end else begin
      vsync_q  <= i_vsync;
      o_vblank <= fall;
      o_onesec <= 1'b0;
      if (fall) begin
        if (frame_cnt == FRAME_LAST) begin
          frame_cnt <= '0;
          o_onesec  <= 1'b1;   // Same cycle as the 60th vblank
        end else begin
          frame_cnt <= frame_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/via_regs.sv
`timescale 1ns/100ps

`include "mac_cfg.svh"

module via_regs (
  input  logic              clk_cpu,
  input  logic              reset,
  input  mac_pkg::mac_bus_t i_bus,
  input  mac_pkg::mac_sel_t i_sel,
  input  logic              i_vsync,
  output logic [7:0]        o_rdata,
  output logic              o_irq,
  output logic              o_overlay,
  output logic [7:0]        o_port_b
);

  import mac_pkg::*;

  via_reg_e    reg_idx;
  logic        access;
  logic        wr;
  logic        rd;
  logic [7:0]  wdata;       // Upper byte lane only

  logic [7:0]  ora;
  logic [7:0]  orb;
  logic        ddrb0;
  logic [15:0] t1_count;    // Storage only, no countdown
  logic [15:0] t1_latch;
  logic [7:0]  t2_latch_low;
  logic [7:0]  sr;
  logic [7:0]  acr;
  logic [6:0]  ier;
  logic [6:0]  ifr;

  logic        t2_load;
  logic        t2_ack;
  logic [15:0] t2_count;
  logic        t2_fire;
  logic        vblank;
  logic        onesec;

  assign reg_idx = via_reg_e'(i_bus.addr[12:9]);
  assign access  = i_sel.via & ~i_bus.uds_n;
  assign wr      = access & ~i_bus.rw;
  assign rd      = access & i_bus.rw;
  assign wdata   = i_bus.wdata[15:8];

  // T2CH write arms, flag clear by read or IFR write acks
  assign t2_load = wr && reg_idx == REG_T2CH;
  assign t2_ack  = (rd && reg_idx == REG_T2CL) || (wr && reg_idx == REG_IFR && wdata[IRQ_T2]);

  // ======================================================================
  // Control registers and interrupt flags
  // ======================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      ora   <= `VIA_ORA_RESET;
      orb   <= `VIA_ORB_RESET;
      ddrb0 <= 1'b1;
      acr   <= '0;
      ier   <= '0;
      ifr   <= '0;
    end else begin
      if (wr) begin
        case (reg_idx)
          REG_ORB:  orb   <= wdata;
          REG_DDRB: ddrb0 <= wdata[0];
          REG_T2CH: ifr[IRQ_T2] <= 1'b0;     // Restart clears old flag
          REG_SR: begin
            if (acr[4:2] == 3'b111) ifr[IRQ_KEYREADY] <= 1'b1;  // Shift out done
          end
          REG_ACR:  acr   <= wdata;
          REG_IFR:  ifr   <= ifr & ~wdata[6:0];  // Write one to clear
          REG_IER: begin
            if (wdata[7]) begin
              ier <= ier | wdata[6:0];
            end else begin
              ier <= ier & ~wdata[6:0];
            end
          end
          REG_ORA:  ora   <= wdata;
          default: ;
        endcase
      end
      // Read side effects
      if (rd) begin
        case (reg_idx)
          REG_ORB: begin
            ifr[IRQ_KEYBIT] <= 1'b0;
            ifr[IRQ_KEYCLK] <= 1'b0;
          end
          REG_T2CL: ifr[IRQ_T2]       <= 1'b0;
          REG_SR:   ifr[IRQ_KEYREADY] <= 1'b0;
          REG_ORA: begin
            ifr[IRQ_ONESEC] <= 1'b0;
            ifr[IRQ_VBLANK] <= 1'b0;
          end
          default: ;
        endcase
      end
      // Events override a clear in the same cycle
      if (t2_fire) ifr[IRQ_T2]     <= 1'b1;
      if (vblank)  ifr[IRQ_VBLANK] <= 1'b1;
      if (onesec)  ifr[IRQ_ONESEC] <= 1'b1;
    end
  end

  // Plain data registers
  always_ff @(posedge clk_cpu) begin
    if (wr) begin
      case (reg_idx)
        REG_T1CL: t1_count[7:0]  <= wdata;
        REG_T1CH: t1_count[15:8] <= wdata;
        REG_T1LL: t1_latch[7:0]  <= wdata;
        REG_T1LH: t1_latch[15:8] <= wdata;
        REG_T2CL: t2_latch_low   <= wdata;  // Used at T2CH write
        REG_SR:   sr             <= wdata;
        default: ;
      endcase
    end
  end

  // ======================================================================
  // Read mux
  // ======================================================================
  always_comb begin
    case (reg_idx)
      REG_ORB:  o_rdata = orb;
      REG_DDRB: o_rdata = {7'b1000011, ddrb0};
      REG_DDRA: o_rdata = 8'h7F;
      REG_T1CL: o_rdata = t1_count[7:0];
      REG_T1CH: o_rdata = t1_count[15:8];
      REG_T1LL: o_rdata = t1_latch[7:0];
      REG_T1LH: o_rdata = t1_latch[15:8];
      REG_T2CL: o_rdata = t2_count[7:0];
      REG_T2CH: o_rdata = t2_count[15:8];
      REG_SR:   o_rdata = sr;
      REG_ACR:  o_rdata = acr;
      REG_PCR:  o_rdata = 8'h00;
      REG_IFR:  o_rdata = {o_irq, ifr};      // Bit 7 is any enabled flag
      REG_IER:  o_rdata = {1'b0, ier};
      REG_ORA:  o_rdata = {1'b1, ora[6:0]};
      default:  o_rdata = `VIA_READ_DEFAULT;
    endcase
  end

  assign o_irq     = |(ifr & ier);
  assign o_overlay = ~ora[4];
  assign o_port_b  = orb;

  // ======================================================================
  // Event sources
  // ======================================================================
  via_timer2 u_via_timer2 (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_load       (t2_load),
    .i_load_count ({wdata, t2_latch_low}),
    .i_ack        (t2_ack),
    .o_count      (t2_count),
    .o_fire       (t2_fire)
  );

  via_frame_events u_via_frame_events (
    .clk_cpu  (clk_cpu),
    .reset    (reset),
    .i_vsync  (i_vsync),
    .o_vblank (vblank),
    .o_onesec (onesec)
  );

endmodule

// File: source/mac_periph_top.sv
`timescale 1ns/100ps

module mac_periph_top (
  input  logic              clk_cpu,
  input  logic              reset,
  input  mac_pkg::mac_bus_t i_bus,
  input  logic [15:0]       i_mem_rdata,  // ROM or RAM data
  input  logic              i_vsync,
  output mac_pkg::mac_sel_t o_sel,
  output logic [15:0]       o_rdata,
  output logic [2:0]        o_ipl_n,
  output logic [7:0]        o_port_b
);

  import mac_pkg::*;

  mac_sel_t   sel;
  logic       overlay;
  logic [7:0] via_rdata;
  logic       via_irq;

  assign o_sel = sel;

  // ======================================================================
  // Address decode and CPU read path
  // ======================================================================
  mac_bus_decode u_mac_bus_decode (
    .i_bus       (i_bus),
    .i_overlay   (overlay),
    .i_via_rdata (via_rdata),
    .i_via_irq   (via_irq),
    .i_mem_rdata (i_mem_rdata),
    .o_sel       (sel),
    .o_rdata     (o_rdata),
    .o_ipl_n     (o_ipl_n)
  );

  // ======================================================================
  // VIA
  // ======================================================================
  via_regs u_via_regs (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .i_bus     (i_bus),
    .i_sel     (sel),
    .i_vsync   (i_vsync),
    .o_rdata   (via_rdata),
    .o_irq     (via_irq),
    .o_overlay (overlay),     // ORA bit 4 inverted
    .o_port_b  (o_port_b)
  );

endmodule

// File: verification/mac_periph_assert.sv
`timescale 1ns/100ps

`include "mac_cfg.svh"

module mac_periph_assert (
  input logic              clk_cpu,
  input logic              reset,
  input mac_pkg::mac_bus_t i_bus,
  input logic              i_vsync,
  input mac_pkg::mac_sel_t o_sel,
  input logic [15:0]       o_rdata,
  input logic [2:0]        o_ipl_n
);

  import mac_pkg::*;

  localparam int unsigned TICK   = `VIA_TICK_DIV;
  localparam int unsigned FRAMES = `VIA_FRAMES_PER_SEC;

  via_reg_e    idx;
  logic        via_wr;
  logic        via_rd;
  logic [7:0]  wbyte;
  logic [7:0]  t2_low;     // Last T2CL write
  logic [15:0] t2_n;       // Count loaded by T2CH
  int unsigned t2_cyc;     // Clocks since the T2CH write
  logic        t2_wait;
  logic [6:0]  ier_m;      // IER as the CPU wrote it
  logic        vs_q;
  logic        vbl_d;
  logic        sec_d;
  logic        vbl_exp;    // Expected IFR VBLANK
  logic        sec_exp;    // Expected IFR ONESEC
  int unsigned frames;

  assign idx    = via_reg_e'(i_bus.addr[12:9]);
  assign via_wr = o_sel.via & ~i_bus.uds_n & ~i_bus.rw;
  assign via_rd = o_sel.via & ~i_bus.uds_n & i_bus.rw;
  assign wbyte  = i_bus.wdata[15:8];

  // ======================================================================
  // Bus-side tracking of Timer 2, IER and the frame flags
  // ======================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      t2_low  <= '0;
      t2_n    <= '0;
      t2_cyc  <= 0;
      t2_wait <= 1'b0;
      ier_m   <= '0;
      vs_q    <= 1'b0;
      vbl_d   <= 1'b0;
      sec_d   <= 1'b0;
      vbl_exp <= 1'b0;
      sec_exp <= 1'b0;
      frames  <= 0;
    end else begin
      t2_cyc <= t2_cyc + 1;
      if (via_wr && idx == REG_T2CL) t2_low <= wbyte;
      if (via_wr && idx == REG_T2CH) begin
        t2_n    <= {wbyte, t2_low};
        t2_cyc  <= 1;
        t2_wait <= 1'b1;
      end else if ((via_rd && idx == REG_T2CL) || (via_wr && idx == REG_IFR)) begin
        t2_wait <= 1'b0;   // Flag taken
      end
      // Bit 7 picks set or clear
      if (via_wr && idx == REG_IER) begin
        if (wbyte[7]) begin
          ier_m <= ier_m | wbyte[6:0];
        end else begin
          ier_m <= ier_m & ~wbyte[6:0];
        end
      end
      // Falling vsync, pulse next cycle, flag the cycle after
      vs_q  <= i_vsync;
      vbl_d <= vs_q & ~i_vsync;
      sec_d <= 1'b0;
      if (vs_q && !i_vsync) begin
        frames <= (frames == FRAMES - 1) ? 0 : frames + 1;
        sec_d  <= (frames == FRAMES - 1);
      end
      if (via_rd && idx == REG_ORA) begin
        vbl_exp <= 1'b0;
        sec_exp <= 1'b0;
      end
      if (vbl_d) vbl_exp <= 1'b1;   // New frame beats a clear
      if (sec_d) sec_exp <= 1'b1;
    end
  end

  // ======================================================================
  // Properties
  // ======================================================================
  a_ipl_reset: assert property (@(posedge clk_cpu) reset |=> o_ipl_n == 3'b111)
    else $error("IPL lines active right after reset");

  // Level 1 exactly when an IFR bit is enabled
  a_ipl_rule: assert property (@(posedge clk_cpu) disable iff (reset)
    via_rd && idx == REG_IFR |->
      o_ipl_n == (((o_rdata[14:8] & ier_m) != '0) ? 3'b110 : 3'b111) &&
      o_rdata[15] == ((o_rdata[14:8] & ier_m) != '0))
    else $error("IPL lines or IFR bit 7 disagree with IFR and IER");

  a_t2_early: assert property (@(posedge clk_cpu) disable iff (reset)
    t2_wait && t2_cyc <= 32'(t2_n) * TICK |-> o_ipl_n == 3'b111)
    else $error("Timer 2 interrupt before its count ran out");

  a_t2_late: assert property (@(posedge clk_cpu) disable iff (reset)
    t2_wait && ier_m[IRQ_T2] && t2_cyc == (32'(t2_n) + 2) * TICK |-> o_ipl_n == 3'b110)
    else $error("Timer 2 interrupt missing after count plus two ticks");

  a_frame_flags: assert property (@(posedge clk_cpu) disable iff (reset)
    via_rd && idx == REG_IFR |->
      o_rdata[8 + IRQ_VBLANK] == vbl_exp && o_rdata[8 + IRQ_ONESEC] == sec_exp)
    else $error("VBLANK or ONESEC flag wrong on an IFR read");

endmodule

bind mac_periph_top mac_periph_assert u_mac_periph_assert (
  .clk_cpu (clk_cpu),
  .reset   (reset),
  .i_bus   (i_bus),
  .i_vsync (i_vsync),
  .o_sel   (o_sel),
  .o_rdata (o_rdata),
  .o_ipl_n (o_ipl_n)
);

// File: verification/tb_mac_periph.sv
`timescale 1ns/100ps

`include "mac_cfg.svh"

module tb_mac_periph;

  import mac_pkg::*;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 8;
  localparam int          DECODE_ADDRS = 200;
  localparam int          T2_MAX       = 20;     // Largest random T2 count
  localparam int          VSYNC_CYCLES = 13;     // Pulse plus three reads
  localparam logic [15:0] MEM_DATA     = 16'hC3A5;
  localparam logic [23:0] VIA_BASE     = 24'hE00000;

  // Reset, two decode passes, worst Timer 2 wait, one second of frames
  localparam int RUN_CYCLES = RESET_CYCLES + 2 * 2 * DECODE_ADDRS
                              + (T2_MAX + 3) * `VIA_TICK_DIV
                              + `VIA_FRAMES_PER_SEC * VSYNC_CYCLES + 400;

  logic        clk_cpu;
  logic        reset;
  mac_bus_t    i_bus;
  logic [15:0] i_mem_rdata;
  logic        i_vsync;
  mac_sel_t    o_sel;
  logic [15:0] o_rdata;
  logic [2:0]  o_ipl_n;
  logic [7:0]  o_port_b;

  int          errors;
  int          tests;
  via_reg_e    store_regs [0:5];

  mac_periph_top u_mac_periph_top (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_bus       (i_bus),
    .i_mem_rdata (i_mem_rdata),
    .i_vsync     (i_vsync),
    .o_sel       (o_sel),
    .o_rdata     (o_rdata),
    .o_ipl_n     (o_ipl_n),
    .o_port_b    (o_port_b)
  );

  always #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;

  // ======================================================================
  // Helpers
  // ======================================================================
  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] got);
    assert (got === exp) else begin
      $display("[FAIL] t=%0d ns %s expected 0x%h got 0x%h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int first_err);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - first_err);
  endtask

  task automatic bus_idle();
    i_bus       = '0;
    i_bus.rw    = 1'b1;
    i_bus.as_n  = 1'b1;
    i_bus.uds_n = 1'b1;
    i_bus.lds_n = 1'b1;
  endtask

  // One access, strobes held across a single rising edge
  task automatic bus_cycle(input logic [23:0] addr, input logic rw, input logic [15:0] wdata,
                           output logic [15:0] rdata, output mac_sel_t sel);
    @(negedge clk_cpu);
    i_bus.addr  = addr[23:1];
    i_bus.rw    = rw;
    i_bus.wdata = wdata;
    i_bus.as_n  = 1'b0;
    i_bus.uds_n = 1'b0;
    i_bus.lds_n = 1'b0;
    #(CLK_PERIOD / 4);   // Comb read path settled
    rdata = o_rdata;
    sel   = o_sel;
    @(negedge clk_cpu);
    bus_idle();
  endtask

  function automatic logic [23:0] via_addr(input via_reg_e idx);
    return VIA_BASE | (24'(idx) << 9);
  endfunction

  task automatic via_write(input via_reg_e idx, input logic [7:0] val);
    logic [15:0] rdata;
    mac_sel_t    sel;
    bus_cycle(via_addr(idx), 1'b0, {val, 8'h00}, rdata, sel);
  endtask

  task automatic via_read(input via_reg_e idx, output logic [7:0] val);
    logic [15:0] rdata;
    mac_sel_t    sel;
    bus_cycle(via_addr(idx), 1'b1, 16'h0000, rdata, sel);
    val = rdata[15:8];   // VIA on the upper lane
  endtask

  task automatic vsync_pulse();
    @(negedge clk_cpu);
    i_vsync = 1'b0;
    repeat (3) @(negedge clk_cpu);
    i_vsync = 1'b1;
    repeat (3) @(negedge clk_cpu);
  endtask

  // Address map as the decode table gives it
  function automatic mac_sel_t expected_sel(input logic [23:0] a, input logic ovl);
    mac_sel_t s;
    s = '0;
    case (a[23:20])
      4'h0, 4'h1, 4'h2, 4'h3: begin
        if (ovl) s.ram = 1'b1;
        else s.rom = 1'b1;
      end
      4'h4:       s.rom  = ~a[17];
      4'h5:       s.scsi = (a[19:12] == 8'h80);
      4'h6:       s.ram  = ~ovl;
      4'h9, 4'hB: s.scc  = 1'b1;
      4'hD:       s.iwm  = 1'b1;
      4'hE:       s.via  = 1'b1;
      default: ;
    endcase
    return s;
  endfunction

  // ======================================================================
  // Watchdog
  // ======================================================================
  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stuck", RUN_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // ======================================================================
  // Tests
  // ======================================================================
  initial begin
    logic [23:0] addr;
    logic [15:0] rdata;
    logic [15:0] n;
    logic [7:0]  b;
    logic [7:0]  val;
    logic        overlay;
    mac_sel_t    sel;
    mac_sel_t    exp_sel;
    int          start;
    int          waited;

    void'($urandom(94));
    clk_cpu     = 1'b0;
    reset       = 1'b1;
    i_mem_rdata = MEM_DATA;
    i_vsync     = 1'b1;   // Idle high, low marks blanking
    bus_idle();
    errors      = 0;
    tests       = 0;
    overlay     = 1'b0;
    store_regs  = '{REG_T1CL, REG_T1CH, REG_T1LL, REG_T1LH, REG_ACR, REG_ORB};
    repeat (RESET_CYCLES) @(negedge clk_cpu);
    reset = 1'b0;

    // Reset values
    start = errors;
    check("o_ipl_n", 16'h0007, 16'(o_ipl_n));
    bus_cycle(via_addr(REG_ORA), 1'b1, 16'h0000, rdata, sel);
    check("o_rdata", {8'hFF, `VIA_LOW_FILL}, rdata);
    via_read(REG_IER, b);
    check("IER", 16'h0000, 16'(b));
    bus_cycle(24'h000000, 1'b1, 16'h0000, rdata, sel);
    exp_sel     = '0;
    exp_sel.rom = 1'b1;   // Not overlaid yet
    check("o_sel", 16'(exp_sel), 16'(sel));
    end_test("reset values", start);

    // Decode, normal map then overlay
    start = errors;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < DECODE_ADDRS; i++) begin
        addr = 24'($urandom);
        if (i % 8 == 0) addr[23:12] = 12'h580;   // SCSI window
        bus_cycle(addr, 1'b1, 16'h0000, rdata, sel);
        exp_sel = expected_sel(addr, overlay);
        check("o_sel", 16'(exp_sel), 16'(sel));
        if (exp_sel.ram || exp_sel.rom) check("o_rdata", MEM_DATA, rdata);
        else if (!exp_sel.via) check("o_rdata", 16'h0000, rdata);
      end
      via_write(REG_ORA, 8'h6F);   // Bit 4 low
      overlay = 1'b1;
    end
    end_test("decode", start);

    // Register storage
    start = errors;
    for (int i = 0; i < 6; i++) begin
      val = 8'($urandom);
      via_write(store_regs[i], val);
      via_read(store_regs[i], b);
      check(store_regs[i].name(), 16'(val), 16'(b));
      if (store_regs[i] == REG_ORB) check("o_port_b", 16'(val), 16'(o_port_b));
    end
    end_test("register storage", start);

    // Timer 2 one-shot and IRQ
    start = errors;
    n = 16'(4 + $urandom % (T2_MAX - 3));
    via_write(REG_IER, 8'hA0);   // Enable T2
    via_write(REG_T2CL, n[7:0]);
    via_write(REG_T2CH, n[15:8]);
    waited = 0;
    while (o_ipl_n != 3'b110 && waited < (n + 3) * `VIA_TICK_DIV) begin
      @(negedge clk_cpu);
      waited++;
    end
    if (o_ipl_n != 3'b110) begin
      $display("Timer 2 never raised the interrupt for count %0d", n);
      errors++;
    end else begin
      assert (waited >= n * `VIA_TICK_DIV && waited <= (n + 2) * `VIA_TICK_DIV) else begin
        $display("Timer 2 fired after %0d cycles, out of window for count %0d", waited, n);
        errors++;
      end
    end
    via_read(REG_IFR, b);
    check("IFR", 16'h00A0, 16'(b));
    via_read(REG_T2CL, b);   // Clears T2
    check("o_ipl_n", 16'h0007, 16'(o_ipl_n));
    via_write(REG_IER, 8'h20);
    end_test("timer 2", start);

    // Frame events over one second
    start = errors;
    for (int f = 1; f <= `VIA_FRAMES_PER_SEC; f++) begin
      vsync_pulse();
      via_read(REG_IFR, b);
      check("IFR", (f == `VIA_FRAMES_PER_SEC) ? 16'h0003 : 16'h0002, 16'(b));
      via_read(REG_ORA, b);
      via_read(REG_IFR, b);
      check("IFR", 16'h0000, 16'(b));
    end
    end_test("frame events", start);

    // Shift register flag and IER clear
    start = errors;
    via_write(REG_ACR, 8'h1C);   // Bits 4:2 set
    via_write(REG_IER, 8'h84);
    val = 8'($urandom);
    via_write(REG_SR, val);
    check("o_ipl_n", 16'h0006, 16'(o_ipl_n));
    via_write(REG_IER, 8'h04);   // Bit 7 low disables
    check("o_ipl_n", 16'h0007, 16'(o_ipl_n));
    via_read(REG_IFR, b);
    check("IFR", 16'h0004, 16'(b));
    via_read(REG_SR, b);
    check("SR", 16'(val), 16'(b));
    via_read(REG_IFR, b);
    check("IFR", 16'h0000, 16'(b));
    end_test("shift register", start);

    $display("Tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+source
source/mac_pkg.sv
source/mac_bus_decode.sv
source/via_timer2.sv
source/via_frame_events.sv
source/via_regs.sv
source/mac_periph_top.sv
verification/mac_periph_assert.sv
verification/tb_mac_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mac_periph -f files.f -o sim_tb

# Exit status of the run is not trusted, the log decides
./obj_dir/sim_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Done: no errors" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
